//--- Makefile
# Verilator build for the magnitude estimator testbench

VERILATOR  ?= verilator
TOP        := tb_mag_approx
RTL_TOP    := mag_approx_top
FILELIST   := compile.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

# Lint the whole project with the testbench as top
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build and run, exit status carries pass or fail
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
source/mag_pkg.sv
source/credit_fifo.sv
source/credit_counter.sv
source/abs_stage.sv
source/sort_stage.sv
source/mag_combine_stage.sv
source/mag_approx_top.sv
verif/tb_mag_approx.sv

//--- source/abs_stage.sv
/*
 * Absolute value stage
 */
module abs_stage (
  input  logic                 clk,
  input  logic                 i_rst,
  input  mag_pkg::iq_sample_t  i_data,
  input  logic                 i_avail,
  input  logic                 i_credit,
  output logic                 o_pop,
  output logic                 o_valid,
  output mag_pkg::iq_abs_t     o_data
);

  import mag_pkg::*;

  logic              can_send;
  logic [SAMP_W-1:0] i_mag;
  logic [SAMP_W-1:0] q_mag;

  credit_counter #(
    .INIT_CREDITS(FIFO_DEPTH)
  ) u_credit_counter (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_send    (o_pop),
    .i_credit  (i_credit),
    .o_can_send(can_send)
  );

  assign o_pop = i_avail && can_send;

  // Two's complement negate, -32768 comes out as 32768 unsigned
  assign i_mag = i_data.i[SAMP_W-1] ? SAMP_W'(-i_data.i) : SAMP_W'(i_data.i);
  assign q_mag = i_data.q[SAMP_W-1] ? SAMP_W'(-i_data.q) : SAMP_W'(i_data.q);

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= o_pop;
    end
  end

  always_ff @(posedge clk) begin
    if (o_pop) begin
      o_data.i_abs <= i_mag;
      o_data.q_abs <= q_mag;
      o_data.last  <= i_data.last;
    end
  end

endmodule

//--- source/credit_counter.sv
/*
 * Sender credit counter
 */
module credit_counter #(
  parameter int INIT_CREDITS = mag_pkg::FIFO_DEPTH
) (
  input  logic clk,
  input  logic i_rst,
  input  logic i_send,
  input  logic i_credit,
  output logic o_can_send
);

  import mag_pkg::*;

  logic [CREDIT_W-1:0] credits;

  // ====================
  // Credit tracking
  // ====================
  // Starts at the receiver's capacity
  always_ff @(posedge clk) begin
    if (i_rst) begin
      credits <= CREDIT_W'(INIT_CREDITS);
    end else begin
      case ({i_send, i_credit})
        // Spend one
        2'b10: begin
          credits <= credits - 1'b1;
        end
        // Receiver freed an entry
        2'b01: begin
          credits <= credits + 1'b1;
        end
        // Idle, or a send and a return cancel out
        default: begin
          credits <= credits;
        end
      endcase
    end
  end

  assign o_can_send = (credits != '0);

endmodule

//--- source/credit_fifo.sv
/*
 * Credit-returning stage buffer
 */
module credit_fifo #(
  parameter type T = mag_pkg::iq_sample_t
) (
  input  logic clk,
  input  logic i_rst,
  input  logic i_valid,
  input  T     i_data,
  input  logic i_pop,
  output logic o_avail,
  output T     o_data,
  output logic o_credit
);

  import mag_pkg::*;

  T                      mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;

  // Circular increment, depth need not be a power of two
  function automatic logic [FIFO_PTR_W-1:0] next_ptr(input logic [FIFO_PTR_W-1:0] ptr);
    logic [FIFO_PTR_W-1:0] nxt;
    if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // ====================
  // Storage
  // ====================
  // The sender never writes without credit, so a write always finds room
  always_ff @(posedge clk) begin
    if (i_valid) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // ====================
  // Pointers and occupancy
  // ====================
  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (i_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({i_valid, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // One credit back upstream for each freed entry
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_credit <= 1'b0;
    end else begin
      o_credit <= i_pop;
    end
  end

  // Head entry
  assign o_avail = (count != '0);
  assign o_data  = mem[rd_ptr];

endmodule

//--- source/mag_approx_top.sv
/*
 * Streaming magnitude estimator
 */
module mag_approx_top (
  input  logic                 clk,
  input  logic                 i_rst,
  input  logic                 i_valid,
  input  mag_pkg::iq_sample_t  i_sample,
  input  logic                 i_credit,
  output logic                 o_credit,
  output logic                 o_valid,
  output mag_pkg::mag_out_t    o_mag
);

  import mag_pkg::*;

  // Buffer 0 to abs
  iq_sample_t buf0_data;
  logic       buf0_avail;
  logic       buf0_pop;

  // Abs to buffer 1 to sort
  logic       abs_valid;
  iq_abs_t    abs_data;
  iq_abs_t    buf1_data;
  logic       buf1_avail;
  logic       buf1_pop;
  logic       buf1_credit;

  // Sort to buffer 2 to combine
  logic       sort_valid;
  max_min_t   sort_data;
  max_min_t   buf2_data;
  logic       buf2_avail;
  logic       buf2_pop;
  logic       buf2_credit;

  // ====================
  // Absolute value
  // ====================
  credit_fifo #(.T(iq_sample_t)) u_buf0 (
    .clk(clk), .i_rst(i_rst), .i_valid(i_valid), .i_data(i_sample),
    .i_pop(buf0_pop), .o_avail(buf0_avail), .o_data(buf0_data), .o_credit(o_credit)
  );

  abs_stage u_abs_stage (
    .clk(clk), .i_rst(i_rst), .i_data(buf0_data), .i_avail(buf0_avail),
    .i_credit(buf1_credit), .o_pop(buf0_pop), .o_valid(abs_valid), .o_data(abs_data)
  );

  // ====================
  // Sort
  // ====================
  credit_fifo #(.T(iq_abs_t)) u_buf1 (
    .clk(clk), .i_rst(i_rst), .i_valid(abs_valid), .i_data(abs_data),
    .i_pop(buf1_pop), .o_avail(buf1_avail), .o_data(buf1_data), .o_credit(buf1_credit)
  );

  sort_stage u_sort_stage (
    .clk(clk), .i_rst(i_rst), .i_data(buf1_data), .i_avail(buf1_avail),
    .i_credit(buf2_credit), .o_pop(buf1_pop), .o_valid(sort_valid), .o_data(sort_data)
  );

  // ====================
  // Weighted sum
  // ====================
  credit_fifo #(.T(max_min_t)) u_buf2 (
    .clk(clk), .i_rst(i_rst), .i_valid(sort_valid), .i_data(sort_data),
    .i_pop(buf2_pop), .o_avail(buf2_avail), .o_data(buf2_data), .o_credit(buf2_credit)
  );

  // Last stage spends the external sink's credits
  mag_combine_stage u_mag_combine_stage (
    .clk(clk), .i_rst(i_rst), .i_data(buf2_data), .i_avail(buf2_avail),
    .i_credit(i_credit), .o_pop(buf2_pop), .o_valid(o_valid), .o_data(o_mag)
  );

endmodule

//--- source/mag_combine_stage.sv
/*
 * Weighted sum stage
 */
module mag_combine_stage (
  input  logic                clk,
  input  logic                i_rst,
  input  mag_pkg::max_min_t   i_data,
  input  logic                i_avail,
  input  logic                i_credit,
  output logic                o_pop,
  output logic                o_valid,
  output mag_pkg::mag_out_t   o_data
);

  import mag_pkg::*;

  logic             can_send;
  logic [MAG_W-1:0] max_scaled;
  logic [MAG_W-1:0] min_scaled;
  logic [MAG_W-1:0] mag_sum;

  // Credits toward the external sink
  credit_counter #(
    .INIT_CREDITS(OUT_CREDITS)
  ) u_credit_counter (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_send    (o_pop),
    .i_credit  (i_credit),
    .o_can_send(can_send)
  );

  assign o_pop = i_avail && can_send;

  // ====================
  // Weighted sum
  // ====================
  // Truncating shift first, then the small numerator
  assign max_scaled = MAG_W'(ALPHA_NUM) * MAG_W'(i_data.max_val >> ALPHA_SHIFT);
  assign min_scaled = MAG_W'(BETA_NUM) * MAG_W'(i_data.min_val >> BETA_SHIFT);

  // Peak stays below 2**MAG_W
  assign mag_sum = max_scaled + min_scaled;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= o_pop;
    end
  end

  always_ff @(posedge clk) begin
    if (o_pop) begin
      o_data.mag  <= mag_sum;
      o_data.last <= i_data.last;
    end
  end

endmodule

//--- source/mag_pkg.sv
/*
 * Magnitude estimator shared definitions
 */
package mag_pkg;

  // ====================
  // Widths
  // ====================
  localparam int SAMP_W = 16;
  // One extra bit for the weighted sum
  localparam int MAG_W  = SAMP_W + 1;

  // ====================
  // Coefficients
  // ====================
  // Alpha = 15/16, beta = 15/32
  localparam int ALPHA_NUM   = 15;
  localparam int ALPHA_SHIFT = 4;
  localparam int BETA_NUM    = 15;
  localparam int BETA_SHIFT  = 5;

  // ====================
  // Buffering and credits
  // ====================
  localparam int FIFO_DEPTH  = 4;
  localparam int OUT_CREDITS = 2;

  localparam int FIFO_PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
  // Wide enough for the larger of the two initial credit counts
  localparam int CREDIT_W =
    $clog2(((FIFO_DEPTH > OUT_CREDITS) ? FIFO_DEPTH : OUT_CREDITS) + 1);

  // ====================
  // Payloads
  // ====================
  typedef struct packed {
    logic signed [SAMP_W-1:0] i;
    logic signed [SAMP_W-1:0] q;
    logic                     last;
  } iq_sample_t;

  typedef struct packed {
    logic [SAMP_W-1:0] i_abs;
    logic [SAMP_W-1:0] q_abs;
    logic              last;
  } iq_abs_t;

  typedef struct packed {
    logic [SAMP_W-1:0] max_val;
    logic [SAMP_W-1:0] min_val;
    logic              last;
  } max_min_t;

  typedef struct packed {
    logic [MAG_W-1:0] mag;
    logic             last;
  } mag_out_t;

endpackage

//--- source/sort_stage.sv
/*
 * Max and min sort stage
 */
module sort_stage (
  input  logic                clk,
  input  logic                i_rst,
  input  mag_pkg::iq_abs_t    i_data,
  input  logic                i_avail,
  input  logic                i_credit,
  output logic                o_pop,
  output logic                o_valid,
  output mag_pkg::max_min_t   o_data
);

  import mag_pkg::*;

  logic can_send;
  logic i_is_max;

  credit_counter #(
    .INIT_CREDITS(FIFO_DEPTH)
  ) u_credit_counter (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_send    (o_pop),
    .i_credit  (i_credit),
    .o_can_send(can_send)
  );

  assign o_pop = i_avail && can_send;

  // Ties go to I
  assign i_is_max = (i_data.i_abs >= i_data.q_abs);

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= o_pop;
    end
  end

  always_ff @(posedge clk) begin
    if (o_pop) begin
      o_data.max_val <= i_is_max ? i_data.i_abs : i_data.q_abs;
      o_data.min_val <= i_is_max ? i_data.q_abs : i_data.i_abs;
      o_data.last    <= i_data.last;
    end
  end

endmodule

//--- verif/tb_mag_approx.sv
/*
 * Magnitude estimator testbench
 */
module tb_mag_approx;

  timeunit 1ns;
  timeprecision 1ps;

  import mag_pkg::*;

  localparam int          CLK_PERIOD      = 100;
  localparam logic [31:0] SEED            = 32'h3de5;
  localparam int          N_DIRECTED      = 8;
  localparam int          N_RANDOM        = 300;
  localparam int          N_STALL         = 20;
  localparam int          STALL_CYCLES    = 50;
  localparam int          N_TOTAL         = N_DIRECTED + N_RANDOM + N_STALL;
  localparam int          WATCHDOG_CYCLES = N_TOTAL * 40 + STALL_CYCLES;

  logic       clk;
  logic       i_rst;
  logic       i_valid;
  iq_sample_t i_sample;
  logic       i_credit = 1'b0;
  logic       o_credit;
  logic       o_valid;
  mag_out_t   o_mag;

  // Scoreboard and credit bookkeeping
  mag_out_t    exp_q[$];
  int          sent_count   = 0;
  int          credits_back = 0;
  int          outstanding  = 0;
  int          recv_count   = 0;
  int          stall_cycles = 0;
  int          credit_wait  = 0;
  logic        sink_hold    = 1'b0;
  logic [31:0] src_lfsr     = SEED;
  logic [31:0] sink_lfsr    = SEED;

  mag_approx_top u_mag_approx_top (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_valid (i_valid),
    .i_sample(i_sample),
    .i_credit(i_credit),
    .o_credit(o_credit),
    .o_valid (o_valid),
    .o_mag   (o_mag)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ====================
  // Helpers
  // ====================
  task automatic fail_run(input string what);
    $display("Failure at %0t: %s", $time, what);
    $display("TESTBENCH FAILED");
    $fatal(1, "%s", what);
  endtask

  task automatic report_mismatch(input string name, input int expected, input int actual);
    $display("ERR time=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
    $display("TESTBENCH FAILED");
    $fatal(1, "value mismatch on %s", name);
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      state = lfsr_next(state);
      val   = {val[30:0], state[0]};
    end
  endtask

  // Reference magnitude alpha * max + beta * min
  // Each fraction is a truncating shift followed by its numerator
  function automatic mag_out_t model_mag(input iq_sample_t s);
    int       ai;
    int       aq;
    int       mx;
    int       mn;
    mag_out_t r;
    ai = int'(s.i);
    aq = int'(s.q);
    if (ai < 0) ai = -ai;
    if (aq < 0) aq = -aq;
    mx = (ai >= aq) ? ai : aq;
    mn = (ai >= aq) ? aq : ai;
    r.mag  = MAG_W'(ALPHA_NUM * (mx >> ALPHA_SHIFT) + BETA_NUM * (mn >> BETA_SHIFT));
    r.last = s.last;
    return r;
  endfunction

  task automatic idle_cycle();
    @(posedge clk);
    i_valid <= 1'b0;
  endtask

  // Sends one sample as soon as an input credit is free
  task automatic send_sample(input logic signed [SAMP_W-1:0] i_val,
                             input logic signed [SAMP_W-1:0] q_val,
                             input logic last, input bit with_gaps);
    iq_sample_t  s;
    logic [31:0] bits;
    bit          done;
    s.i    = i_val;
    s.q    = q_val;
    s.last = last;
    if (with_gaps) begin
      draw_bits(src_lfsr, 2, bits);
      if (bits[1:0] == 2'd0) begin
        idle_cycle();
        idle_cycle();
      end
    end
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      if (FIFO_DEPTH - sent_count + credits_back > 0) begin
        i_valid    <= 1'b1;
        i_sample   <= s;
        sent_count <= sent_count + 1;
        exp_q.push_back(model_mag(s));
        done = 1'b1;
      end else begin
        i_valid <= 1'b0;
        stall_cycles++;
      end
    end
  endtask

  // ====================
  // Checkers
  // ====================
  initial begin : reset_check
    repeat (5) begin
      @(negedge clk);
      assert (!o_valid && !o_credit)
        else fail_run("o_valid or o_credit high during or just after reset");
    end
  end

  always @(posedge clk) begin : output_monitor
    mag_out_t exp_val;
    if (!i_rst && o_valid) begin
      assert (exp_q.size() != 0) else fail_run("output arrived with no sample outstanding");
      if (exp_q.size() != 0) begin
        exp_val = exp_q.pop_front();
        assert (o_mag.mag == exp_val.mag)
          else report_mismatch("o_mag.mag", int'(exp_val.mag), int'(o_mag.mag));
        assert (o_mag.last == exp_val.last)
          else report_mismatch("o_mag.last", int'(exp_val.last), int'(o_mag.last));
        recv_count <= recv_count + 1;
      end
    end
  end

  // Returned input credits never outnumber samples sent
  always @(posedge clk) begin : input_credit_track
    if (i_rst) begin
      credits_back <= 0;
    end else if (o_credit) begin
      assert (credits_back < sent_count)
        else fail_run("DUT returned more input credits than samples sent");
      credits_back <= credits_back + 1;
    end
  end

  // Sink with random credit return delay
  always @(posedge clk) begin : sink_model
    int          pending;
    logic [31:0] bits;
    if (i_rst) begin
      outstanding <= 0;
      credit_wait <= 0;
      i_credit    <= 1'b0;
    end else begin
      if (o_valid) begin
        assert (outstanding < OUT_CREDITS)
          else fail_run("DUT sent an output with no output credit left");
      end
      pending = outstanding + int'(o_valid) - int'(i_credit);
      outstanding <= pending;
      if (pending > 0 && !sink_hold && credit_wait == 0) begin
        i_credit <= 1'b1;
        draw_bits(sink_lfsr, 2, bits);
        credit_wait <= int'(bits[1:0]);
      end else begin
        i_credit <= 1'b0;
        if (credit_wait > 0) credit_wait <= credit_wait - 1;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    fail_run("timeout, outputs or credits never completed");
  end

  // ====================
  // Stimulus
  // ====================
  initial begin : stimulus
    logic [31:0]              bits;
    logic signed [SAMP_W-1:0] iv;
    logic signed [SAMP_W-1:0] qv;
    int                       frame_left;
    int                       stall_before;
    i_rst    = 1'b1;
    i_valid  = 1'b0;
    i_sample = '0;
    repeat (4) @(posedge clk);
    i_rst <= 1'b0;

    // Corner values
    send_sample(16'sd0, 16'sd0, 1'b0, 1'b1);
    send_sample(-16'sd32768, -16'sd32768, 1'b0, 1'b1);
    send_sample(16'sd32767, 16'sd32767, 1'b0, 1'b1);
    send_sample(-16'sd32768, 16'sd32767, 1'b1, 1'b1);
    send_sample(16'sd32767, -16'sd32768, 1'b0, 1'b1);
    send_sample(16'sd1234, 16'sd1234, 1'b0, 1'b1);
    send_sample(-16'sd500, -16'sd500, 1'b0, 1'b1);
    send_sample(16'sd100, -16'sd7000, 1'b1, 1'b1);

    // Random frames of 1 to 8 samples
    frame_left = 0;
    for (int n = 0; n < N_RANDOM; n++) begin
      if (frame_left == 0) begin
        draw_bits(src_lfsr, 3, bits);
        frame_left = int'(bits[2:0]) + 1;
      end
      draw_bits(src_lfsr, 16, bits);
      iv = bits[15:0];
      draw_bits(src_lfsr, 16, bits);
      qv = bits[15:0];
      frame_left--;
      send_sample(iv, qv, (frame_left == 0) || (n == N_RANDOM - 1), 1'b1);
    end

    // Sink withholds credits while the source pushes back to back
    stall_before = stall_cycles;
    fork
      begin
        sink_hold <= 1'b1;
        repeat (STALL_CYCLES) @(posedge clk);
        sink_hold <= 1'b0;
      end
      begin
        for (int n = 0; n < N_STALL; n++) begin
          draw_bits(src_lfsr, 16, bits);
          iv = bits[15:0];
          draw_bits(src_lfsr, 16, bits);
          qv = bits[15:0];
          send_sample(iv, qv, n == N_STALL - 1, 1'b0);
        end
      end
    join
    assert (stall_cycles > stall_before)
      else fail_run("source never stalled during output back-pressure");
    idle_cycle();

    // Drain until every output is received and credited
    while (exp_q.size() != 0 || outstanding != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);

    if (FIFO_DEPTH - sent_count + credits_back == FIFO_DEPTH && sent_count == N_TOTAL &&
        recv_count == N_TOTAL) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      fail_run("sample or credit count wrong after drain");
    end
  end

endmodule
